/* src/alien_pkg.sv */
// Shared constants for the invader row renderer
// Screen coordinate widths, sprite geometry, formation layout
// and the march rule limits
`default_nettype none

package alien_pkg;

    // Pixel and origin coordinate width
    localparam int COORD_W = 12;

    // Colour depth of the pixel output
    localparam int COLOR_W = 4;

    // Formation layout
    localparam int NUM_ALIENS = 5;
    localparam int SLOT_PITCH = 30;

    // Invader sprite size in pixels
    localparam int SPRITE_ROWS = 16;
    localparam int SPRITE_COLS = 22;

    // Origin of the formation after reset
    localparam int START_ROW = 46;
    localparam int START_COL = 245;

    // March step sizes
    localparam int STEP_COL = 12;
    localparam int STEP_ROW = 24;

    // Screen edges that turn the formation around
    localparam int LEFT_LIMIT  = 21;
    localparam int RIGHT_LIMIT = 500;

    // Formation below this row has reached the player
    localparam int INVADE_ROW = 400;

    // Colour of a lit sprite pixel against a zero background
    localparam int PIXEL_ON = 15;

endpackage

`default_nettype wire

/* src/formation_march.sv */
// Formation march engine
// Step timebase gated by march_enable, sideways steps,
// edge drop with direction reversal and the invasion flag
`timescale 1ns/10ps
`default_nettype none

module formation_march #(
    parameter int unsigned MOVE_PERIOD = 16_000_000
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          march_enable,
    output logic [alien_pkg::COORD_W-1:0] origin_row,
    output logic [alien_pkg::COORD_W-1:0] origin_col,
    output logic                          moving_left,
    output logic                          invaded
);
    import alien_pkg::*;

    localparam int CNT_W = (MOVE_PERIOD > 1) ? $clog2(MOVE_PERIOD) : 1;

    logic [CNT_W-1:0] step_count;
    logic             step_due;
    logic             at_edge;

    // Last enabled cycle of the period
    assign step_due = march_enable && (step_count == CNT_W'(MOVE_PERIOD - 1));

    // Edge test depends on the current heading
    assign at_edge = moving_left ? (origin_col < COORD_W'(LEFT_LIMIT))
                                 : (origin_col > COORD_W'(RIGHT_LIMIT));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            step_count  <= '0;
            origin_row  <= COORD_W'(START_ROW);
            origin_col  <= COORD_W'(START_COL);
            moving_left <= 1'b0;
        end
        else if (step_due)
        begin
            step_count <= '0;
            if (at_edge)
            begin
                // Drop one line and turn around
                origin_row  <= origin_row + COORD_W'(STEP_ROW);
                moving_left <= !moving_left;
            end
            else if (moving_left)
            begin
                origin_col <= origin_col - COORD_W'(STEP_COL);
            end
            else
            begin
                origin_col <= origin_col + COORD_W'(STEP_COL);
            end
        end
        else if (march_enable)
        begin
            step_count <= step_count + 1'b1;
        end
    end

    // Game over once the row is low enough
    assign invaded = origin_row > COORD_W'(INVADE_ROW);

endmodule

`default_nettype wire

/* src/slot_locator.sv */
// Pixel pipeline stage 1
// Band test below the formation origin, per-alien column
// window test and local sprite coordinates of the hit alien
`timescale 1ns/10ps
`default_nettype none

module slot_locator (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [alien_pkg::COORD_W-1:0]    pixel_row,
    input  logic [alien_pkg::COORD_W-1:0]    pixel_col,
    input  logic [alien_pkg::COORD_W-1:0]    origin_row,
    input  logic [alien_pkg::COORD_W-1:0]    origin_col,
    output logic [3:0]                       local_row,
    output logic [4:0]                       local_col,
    output logic [alien_pkg::NUM_ALIENS-1:0] slot_hit,
    output logic                             in_band
);
    import alien_pkg::*;

    logic [COORD_W-1:0]    row_off;
    logic [COORD_W-1:0]    col_off;
    logic                  row_past;
    logic                  col_past;
    logic                  band_next;
    logic [NUM_ALIENS-1:0] hit_next;
    logic [COORD_W-1:0]    local_col_next;

    // Sprites start one pixel past the origin in both axes
    assign row_past = pixel_row > origin_row;
    assign col_past = pixel_col > origin_col;
    assign row_off  = pixel_row - origin_row - COORD_W'(1);
    assign col_off  = pixel_col - origin_col - COORD_W'(1);

    // 16 rows below the origin
    assign band_next = row_past && (row_off < COORD_W'(SPRITE_ROWS));

    // Windows are disjoint, so at most one slot matches
    always_comb
    begin
        hit_next       = '0;
        local_col_next = '0;
        for (int i = 0; i < NUM_ALIENS; i++)
        begin
            if (col_past
                && (col_off >= COORD_W'(i * SLOT_PITCH))
                && (col_off < COORD_W'(i * SLOT_PITCH + SPRITE_COLS)))
            begin
                hit_next[i]    = 1'b1;
                local_col_next = col_off - COORD_W'(i * SLOT_PITCH);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot_hit <= '0;
            in_band  <= 1'b0;
        end
        else
        begin
            slot_hit <= hit_next;
            in_band  <= band_next;
        end
    end

    // Coordinates inside the sprite
    always_ff @(posedge clk)
    begin
        local_row <= row_off[3:0];
        local_col <= local_col_next[4:0];
    end

endmodule

`default_nettype wire

/* src/sprite_bitmap.sv */
// Pixel pipeline stage 2
// Invader shape as a constant row table, lit pixel lookup,
// registered colour and per-alien box hit flags
`timescale 1ns/10ps
`default_nettype none

module sprite_bitmap (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [3:0]                       local_row,
    input  logic [4:0]                       local_col,
    input  logic [alien_pkg::NUM_ALIENS-1:0] slot_hit,
    input  logic                             in_band,
    output logic [alien_pkg::COLOR_W-1:0]    pixel_color,
    output logic [alien_pkg::NUM_ALIENS-1:0] alien_active
);
    import alien_pkg::*;

    // Bit c of an entry is local column c
    localparam logic [SPRITE_COLS-1:0] SHAPE [SPRITE_ROWS] = '{
        // Antenna tips
        22'h03_0030,
        22'h03_0030,
        // Antenna stems
        22'h00_C0C0,
        22'h00_C0C0,
        // Head
        22'h03_FFF0,
        22'h03_FFF0,
        // Eyes
        22'h0F_3F3C,
        22'h0F_3F3C,
        // Full width body
        22'h3F_FFFF,
        22'h3F_FFFF,
        // Legs and arms
        22'h33_0033,
        22'h33_0033,
        22'h33_0033,
        22'h33_0033,
        // Feet with a gap in the middle
        22'h00_F3C0,
        22'h00_F3C0
    };

    logic [SPRITE_COLS-1:0] row_bits;
    logic                   box_hit;
    logic                   lit;

    assign row_bits = SHAPE[local_row];
    assign box_hit  = in_band && (|slot_hit);

    always_comb
    begin
        lit = 1'b0;
        if (box_hit)
        begin
            lit = row_bits[local_col];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pixel_color  <= '0;
            alien_active <= '0;
        end
        else
        begin
            pixel_color  <= lit ? COLOR_W'(PIXEL_ON) : '0;
            // Whole box counts whether lit or not
            alien_active <= in_band ? slot_hit : '0;
        end
    end

endmodule

`default_nettype wire

/* src/alien_formation_top.sv */
// Top level of the invader row renderer
// March engine plus the two stage pixel pipeline
`timescale 1ns/10ps
`default_nettype none

module alien_formation_top #(
    parameter int unsigned MOVE_PERIOD = 16_000_000
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [alien_pkg::COORD_W-1:0]    pixel_row,
    input  logic [alien_pkg::COORD_W-1:0]    pixel_col,
    input  logic                             march_enable,
    output logic [alien_pkg::COLOR_W-1:0]    pixel_color,
    output logic [alien_pkg::NUM_ALIENS-1:0] alien_active,
    output logic [alien_pkg::COORD_W-1:0]    formation_row,
    output logic [alien_pkg::COORD_W-1:0]    formation_col,
    output logic                             moving_left,
    output logic                             invaded
);
    import alien_pkg::*;

    logic [COORD_W-1:0]    origin_row;
    logic [COORD_W-1:0]    origin_col;
    logic [3:0]            local_row;
    logic [4:0]            local_col;
    logic [NUM_ALIENS-1:0] slot_hit;
    logic                  in_band;

    formation_march #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) formation_march_inst (
        .clk          (clk),
        .reset        (reset),
        .march_enable (march_enable),
        .origin_row   (origin_row),
        .origin_col   (origin_col),
        .moving_left  (moving_left),
        .invaded      (invaded)
    );

    // Origin is sampled together with the pixel
    slot_locator slot_locator_inst (
        .clk        (clk),
        .reset      (reset),
        .pixel_row  (pixel_row),
        .pixel_col  (pixel_col),
        .origin_row (origin_row),
        .origin_col (origin_col),
        .local_row  (local_row),
        .local_col  (local_col),
        .slot_hit   (slot_hit),
        .in_band    (in_band)
    );

    sprite_bitmap sprite_bitmap_inst (
        .clk          (clk),
        .reset        (reset),
        .local_row    (local_row),
        .local_col    (local_col),
        .slot_hit     (slot_hit),
        .in_band      (in_band),
        .pixel_color  (pixel_color),
        .alien_active (alien_active)
    );

    assign formation_row = origin_row;
    assign formation_col = origin_col;

endmodule

`default_nettype wire

/* testbench/alien_formation_checker.sv */
// Concurrent assertions for the invader row renderer
// Output consistency and march behaviour, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module alien_formation_checker (
    input logic                             clk,
    input logic                             reset,
    input logic                             march_enable,
    input logic [alien_pkg::COLOR_W-1:0]    pixel_color,
    input logic [alien_pkg::NUM_ALIENS-1:0] alien_active,
    input logic [alien_pkg::COORD_W-1:0]    formation_row,
    input logic [alien_pkg::COORD_W-1:0]    formation_col
);

    // Alien windows never overlap
    one_alien_active: assert property (
        @(posedge clk) disable iff (reset) $onehot0(alien_active)
    ) else $error("alien_active has more than one bit set");

    // Lit pixels only inside some alien box
    color_needs_alien: assert property (
        @(posedge clk) disable iff (reset) (pixel_color != '0) |-> (alien_active != '0)
    ) else $error("pixel_color is lit with no alien_active bit");

    // Paused march keeps the origin
    origin_holds: assert property (
        @(posedge clk) disable iff (reset)
        !march_enable |=> ($stable(formation_row) && $stable(formation_col))
    ) else $error("formation origin moved while march_enable was low");

    // Drops only go down the screen
    row_never_up: assert property (
        @(posedge clk) disable iff (reset) formation_row >= $past(formation_row)
    ) else $error("formation_row decreased");

endmodule

bind alien_formation_top alien_formation_checker alien_formation_checker_inst (
    .clk           (clk),
    .reset         (reset),
    .march_enable  (march_enable),
    .pixel_color   (pixel_color),
    .alien_active  (alien_active),
    .formation_row (formation_row),
    .formation_col (formation_col)
);

`default_nettype wire

/* testbench/tb_alien_formation.sv */
// Testbench for the invader row renderer
// Reads probe and march records from the test data file, drives the
// pixel pipeline and the march engine, and checks every response
`timescale 1ns/10ps
`default_nettype none

module tb_alien_formation;
    import alien_pkg::*;

    localparam int MOVE_PERIOD  = 4;
    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;

    // Six hex words per record
    localparam int          RECORD_WORDS = 6;
    localparam int          MAX_RECORDS  = 64;
    localparam logic [31:0] KIND_END     = 32'd0;
    localparam logic [31:0] KIND_PROBE   = 32'd1;
    localparam logic [31:0] KIND_MARCH   = 32'd2;

    logic                  clk;
    logic                  reset;
    logic [COORD_W-1:0]    pixel_row;
    logic [COORD_W-1:0]    pixel_col;
    logic                  march_enable;
    logic [COLOR_W-1:0]    pixel_color;
    logic [NUM_ALIENS-1:0] alien_active;
    logic [COORD_W-1:0]    formation_row;
    logic [COORD_W-1:0]    formation_col;
    logic                  moving_left;
    logic                  invaded;

    logic [31:0] test_words [RECORD_WORDS*MAX_RECORDS];
    int          probe_total;
    int          march_total;

    alien_formation_top #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) alien_formation_top_inst (
        .clk           (clk),
        .reset         (reset),
        .pixel_row     (pixel_row),
        .pixel_col     (pixel_col),
        .march_enable  (march_enable),
        .pixel_color   (pixel_color),
        .alien_active  (alien_active),
        .formation_row (formation_row),
        .formation_col (formation_col),
        .moving_left   (moving_left),
        .invaded       (invaded)
    );

    always #CLK_HALF clk = !clk;

    function automatic logic [31:0] field_of(input int rec, input int pos);
        return test_words[rec * RECORD_WORDS + pos];
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic drive_probe(input int rec);
        pixel_row = COORD_W'(field_of(rec, 1));
        pixel_col = COORD_W'(field_of(rec, 2));
    endtask

    task automatic check_probe(input int rec);
        string where;
        where = $sformatf("probe at row %0d col %0d", field_of(rec, 1), field_of(rec, 2));
        check_value(32'(pixel_color), field_of(rec, 3), {where, " colour"});
        check_value(32'(alien_active), field_of(rec, 4), {where, " alien_active"});
        probe_total++;
    endtask

    // Back to back pixels with each result two edges after its drive
    task automatic run_probes(input int first, input int count);
        drive_probe(first);
        for (int j = 1; j <= count + 1; j++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (j >= 2)
            begin
                check_probe(first + j - 2);
            end
            if (j < count)
            begin
                drive_probe(first + j);
            end
        end
    endtask

    // Each step or drop moves the origin once
    task automatic run_march(input int rec);
        int                   steps;
        int                   seen;
        int                   cycles;
        int                   limit;
        logic [2*COORD_W-1:0] last_pos;
        steps    = int'(field_of(rec, 1));
        seen     = 0;
        cycles   = 0;
        limit    = steps * MOVE_PERIOD * 2 + 16;
        last_pos = {formation_row, formation_col};
        march_enable = (steps != 0);
        while ((seen < steps) && (cycles < limit))
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            if ({formation_row, formation_col} != last_pos)
            begin
                seen++;
                last_pos = {formation_row, formation_col};
            end
        end
        march_enable = 1'b0;
        if (seen < steps)
        begin
            $display("Timeout: formation made %0d of %0d steps in %0d cycles",
                     seen, steps, cycles);
            $display("TB FAILED");
            $fatal(1, "March did not complete");
        end
        check_value(32'(formation_row), field_of(rec, 2), "formation_row");
        check_value(32'(formation_col), field_of(rec, 3), "formation_col");
        check_value(32'(moving_left), field_of(rec, 4), "moving_left");
        check_value(32'(invaded), field_of(rec, 5), "invaded");
        march_total++;
    endtask

    initial
    begin
        int          rec;
        int          run_len;
        logic [31:0] kind;
        bit          end_seen;
        clk          = 1'b0;
        reset        = 1'b1;
        // Lit pixel of alien 0 at the start origin
        pixel_row    = COORD_W'(47);
        pixel_col    = COORD_W'(250);
        march_enable = 1'b0;
        probe_total  = 0;
        march_total  = 0;
        end_seen     = 1'b0;
        $readmemh("testbench/alien_testdata.txt", test_words);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_value(32'(pixel_color), 32'd0, "pixel_color after reset");
        check_value(32'(alien_active), 32'd0, "alien_active after reset");

        rec = 0;
        while (!end_seen && (rec < MAX_RECORDS))
        begin
            kind = field_of(rec, 0);
            if (kind === KIND_PROBE)
            begin
                run_len = 0;
                while ((rec + run_len < MAX_RECORDS)
                       && (field_of(rec + run_len, 0) === KIND_PROBE))
                begin
                    run_len++;
                end
                run_probes(rec, run_len);
                rec += run_len;
            end
            else if (kind === KIND_MARCH)
            begin
                run_march(rec);
                rec++;
            end
            else if (kind === KIND_END)
            begin
                end_seen = 1'b1;
            end
            else
            begin
                $display("Record %0d of the data file has an unknown kind %h", rec, kind);
                $display("TB FAILED");
                $fatal(1, "Bad data file");
            end
        end

        if (!end_seen || (probe_total == 0) || (march_total == 0))
        begin
            $display("The data file had no end record or held no probe or march records");
            $display("TB FAILED");
            $fatal(1, "Bad data file");
        end
        else
        begin
            $display("%0d probes and %0d marches checked", probe_total, march_total);
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/alien_testdata.txt */
// Invader row test records, six hex words per line
// Probe: 1 row col colour alien_active 0
// March: 2 steps row col moving_left invaded, End: all zero
// Reset state of the formation
2 0 2E F5 0 0
// Probes at the starting origin, row 46 col 245
1 2F FA F 01 0
1 30 107 F 01 0
1 31 11A F 02 0
1 37 132 F 04 0
1 37 147 F 04 0
1 37 148 0 00 0
1 3D 15A 0 08 0
1 3D 15B 0 08 0
1 3E 159 F 08 0
1 3E 15C F 08 0
1 3F FA 0 00 0
1 2E FA 0 00 0
1 39 16E F 10 0
1 39 170 0 10 0
1 35 170 F 10 0
1 35 175 0 10 0
1 39 183 F 10 0
1 33 F6 0 01 0
1 33 FA F 01 0
// Right to the edge, drop, then left to the other edge
2 3 2E 119 0 0
2 13 2E 1FD 0 0
2 1 46 1FD 1 0
2 1 46 1F1 1 0
2 28 46 11 1 0
2 1 5E 11 0 0
// Twelve more drops, then the fifteenth passes row 400
2 1F8 17E 11 0 0
2 29 17E 1FD 0 0
2 1 196 1FD 1 1
2 1 196 1F1 1 1
// Probes at the new origin, row 406 col 497
1 197 1F6 F 01 0
1 19F 210 F 02 0
1 1A5 238 0 04 0
1 1A6 252 F 08 0
1 19D 272 F 10 0
1 1A7 1F6 0 00 0
1 19A 208 0 00 0
0 0 0 0 0 0

/* sim.f */
src/alien_pkg.sv
src/formation_march.sv
src/slot_locator.sv
src/sprite_bitmap.sv
src/alien_formation_top.sv
testbench/alien_formation_checker.sv
testbench/tb_alien_formation.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the invader row testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_alien_formation \
    -Mdir obj_dir \
    -o tb_alien_formation

sim_output=$(./obj_dir/tb_alien_formation 2>&1) || true
echo "$sim_output"

if grep -q "^TB PASSED$" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
